// ==== project.f ====
+incdir+.
alu_isa_pkg.sv
alu_approx_pkg.sv
ec_ripple_adder.sv
carry_select_block.sv
approx_adder.sv
alu_decoder.sv
alu_core.sv
tb_alu.sv

// ==== run.sh ====
#!/bin/sh
# Build tb_alu with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_alu -f project.f -o tb_alu_sim &&
./obj_dir/tb_alu_sim | tee /dev/stderr | grep -qF "*** PASSED ***" &&
echo "simulation ok" ||
{ echo "simulation did not pass"; exit 1; }

// ==== alu_patterns.hex ====
// opcode _ funct3 _ funct7 _ rs1 _ rs2 _ immediate _ accuracy_control _ result _ illegal _ test
// Approximation on means accuracy_control bit 0 set, error field in bits 10:3
33_0_00_7fffffff_00000001_00000000_00000000_80000000_0_01
33_0_20_00000005_00000007_00000000_00000000_fffffffe_0_02
33_1_00_00000001_00000024_00000000_00000000_00000010_0_03
33_2_00_ffffffff_00000001_00000000_00000000_00000001_0_04
33_3_00_ffffffff_00000001_00000000_00000000_00000000_0_05
33_4_00_f0f0f0f0_0ff00ff0_00000000_00000000_ff00ff00_0_06
33_5_00_80000000_00000004_00000000_00000000_08000000_0_07
33_5_20_80000000_00000004_00000000_00000000_f8000000_0_08
33_6_00_12340000_00005678_00000000_00000000_12345678_0_09
33_7_00_ffff0000_0f0f0f0f_00000000_00000000_0f0f0000_0_0a
13_0_00_00000010_deadbeef_ffffffff_00000000_0000000f_0_0b
13_2_00_fffffffe_deadbeef_ffffffff_00000000_00000001_0_0c
13_3_00_00000005_00000003_ffffffff_00000000_00000001_0_0d
13_4_00_0000ffff_deadbeef_fffff0f0_00000000_ffff0f0f_0_0e
13_1_00_00000003_deadbeef_00000023_00000000_00000018_0_0f
13_5_00_f0000000_deadbeef_0000003c_00000000_0000000f_0_10
13_5_20_f0000000_deadbeef_0000001c_00000000_ffffffff_0_11
13_6_00_00000100_deadbeef_00000011_00000000_00000111_0_12
13_7_00_12345678_deadbeef_000000ff_00000000_00000078_0_13
33_0_00_00000003_00000001_00000000_00000001_00000006_0_14
33_0_00_00000003_00000001_00000000_000007f9_00000004_0_15
33_0_00_00000010_00000030_00000000_00000001_00000020_0_16
33_0_00_12345600_0ff0ff00_00000000_00000001_22255500_0_17
33_4_00_f0f0f0f0_0ff00ff0_00000000_00000001_ff00ff00_0_18
33_5_20_80000000_00000004_00000000_00000001_f8000000_0_19
33_2_00_80000000_00000001_00000000_00000001_00000001_0_1a
17_0_00_00000003_00000001_00000000_00000000_00000000_1_1b
13_1_20_00000003_deadbeef_00000002_00000000_00000000_1_1c

// ==== tb_checks.svh ====
/*
  Compare tasks for tb_alu, included inside the module body.
  The first error stops the run.
*/
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Report, then stop the simulation
task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "tb_alu stopped at the first error");
endtask

// ------------------------------------------------------------
// One compare task per kind of result
// ------------------------------------------------------------
task automatic check_result(input string                      name,
                            input logic [alu_isa_pkg::XLEN-1:0] expected,
                            input logic [alu_isa_pkg::XLEN-1:0] actual);
    if (actual !== expected) begin
        abort_run($sformatf("mismatch %s result expected 0x%08h actual 0x%08h",
                            name, expected, actual));
    end
endtask

task automatic check_illegal(input string name,
                             input bit    expected,
                             input bit    actual);
    if (actual != expected) begin
        abort_run($sformatf("mismatch %s illegal expected %0b actual %0b",
                            name, expected, actual));
    end
endtask

`endif

// ==== tb_alu.sv ====
/*
  Testbench for alu_core with APX_LEN 8.
  Replays alu_patterns.hex one strobe at a time, then a back-to-back random stream.
  Run from the project root so the pattern file is found.
*/
`timescale 1ns/1ps

module tb_alu;

    import alu_isa_pkg::*;
    import alu_approx_pkg::*;

    localparam int NPAT    = 28;               // Records in the pattern file
    localparam int NRAND   = 18;               // Strobes in the random stream
    localparam int TIMEOUT = 10;               // Cycles allowed per wait

    // Pattern record, every field padded to whole hex digits
    typedef struct packed {
        logic [7:0]      opcode;
        logic [3:0]      funct3;
        logic [7:0]      funct7;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] immediate;
        logic [XLEN-1:0] acc;
        logic [XLEN-1:0] exp_result;
        logic [3:0]      exp_illegal;          // Only bit 0 used
        logic [7:0]      test_num;
    } pattern_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    logic [ACC_CTRL_W-1:0] accuracy_control;
    opcode_e               opcode;
    funct3_e               funct3;
    funct7_e               funct7;
    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [XLEN-1:0]       immediate;
    logic                  out_valid;
    logic [XLEN-1:0]       result;
    logic                  illegal;

    logic [$bits(pattern_t)-1:0] pat_mem [NPAT];
    logic [XLEN-1:0]             stream_exp [NRAND]; // Exact results of the stream
    integer                      seed = 32'h7451_b15d;

    always #20 clk = ~clk;                     // 40 ns period

    alu_core #(
        .APX_LEN (8)
    ) dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .accuracy_control (accuracy_control),
        .opcode           (opcode),
        .funct3           (funct3),
        .funct7           (funct7),
        .rs1              (rs1),
        .rs2              (rs2),
        .immediate        (immediate),
        .out_valid        (out_valid),
        .result           (result),
        .illegal          (illegal)
    );

    `include "tb_checks.svh"

    // One strobe, in_valid dropped on the capture edge
    task automatic apply_pattern(input pattern_t p);
        @(posedge clk);
        in_valid         <= 1'b1;
        opcode           <= opcode_e'(p.opcode[6:0]); // May be outside the enum
        funct3           <= funct3_e'(p.funct3[2:0]);
        funct7           <= funct7_e'(p.funct7[6:0]);
        rs1              <= p.rs1;
        rs2              <= p.rs2;
        immediate        <= p.immediate;
        accuracy_control <= p.acc;
        @(posedge clk);
        in_valid         <= 1'b0;
    endtask

    // Sample on falling edges, result due on the first one
    task automatic wait_out_valid(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            abort_run($sformatf("%s: out_valid never went high", name));
        end
        if (n != 0) begin
            abort_run($sformatf("%s: out_valid came %0d cycles late", name, n));
        end
    endtask

    initial begin
        pattern_t        cur;
        string           name;
        logic [XLEN-1:0] ra;
        logic [XLEN-1:0] rb;

        rst_n            = 1'b0;
        in_valid         = 1'b0;
        accuracy_control = '0;
        opcode           = OP;
        funct3           = F3_ADD_SUB;
        funct7           = F7_BASE;
        rs1              = '0;
        rs2              = '0;
        immediate        = '0;
        $readmemh("alu_patterns.hex", pat_mem);

        // ------------------------------------------------------------
        // Reset for two cycles, outputs idle
        // ------------------------------------------------------------
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_result("reset", '0, result);
        check_illegal("reset", 1'b0, illegal);
        if (out_valid) begin
            abort_run("out_valid is high during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;

        // ------------------------------------------------------------
        // Pattern replay
        // ------------------------------------------------------------
        for (int i = 0; i < NPAT; i++) begin
            cur  = pattern_t'(pat_mem[i]);
            name = $sformatf("test %0d", cur.test_num);
            apply_pattern(cur);
            wait_out_valid(name);
            check_result(name, cur.exp_result, result);
            check_illegal(name, cur.exp_illegal[0], illegal);
        end

        // ------------------------------------------------------------
        // Back-to-back stream, approximation off, error bits random
        // ------------------------------------------------------------
        for (int i = 0; i <= NRAND; i++) begin
            @(posedge clk);
            if (i < NRAND) begin
                ra = $random(seed);
                rb = $random(seed);
                case (i % 3)
                    0: begin
                        stream_exp[i] = ra + rb;
                        funct3 <= F3_ADD_SUB;
                        funct7 <= F7_BASE;
                    end
                    1: begin
                        stream_exp[i] = ra - rb;
                        funct3 <= F3_ADD_SUB;
                        funct7 <= F7_ALT;
                    end
                    default: begin
                        stream_exp[i] = ra ^ rb;
                        funct3 <= F3_XOR;
                        funct7 <= F7_BASE;
                    end
                endcase
                in_valid         <= 1'b1;
                opcode           <= OP;
                rs1              <= ra;
                rs2              <= rb;
                accuracy_control <= $random(seed) & 32'hffff_fffe; // Enable bit clear
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                if (!out_valid) begin
                    abort_run($sformatf("stream %0d: out_valid low in the stream", i - 1));
                end
                check_result($sformatf("stream %0d", i - 1), stream_exp[i-1], result);
                check_illegal($sformatf("stream %0d", i - 1), 1'b0, illegal);
            end
        end
        @(negedge clk);
        if (out_valid) begin
            abort_run("out_valid still high after the stream ended");
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== alu_core.sv ====
/*
  RV32I ALU for OP and OP_IMM with an approximate add path.
  One register stage, result one cycle after each in_valid strobe.
  No back-pressure, a new instruction may enter every cycle.
*/
`timescale 1ns/1ps

module alu_core #(
    parameter int APX_LEN = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [alu_approx_pkg::ACC_CTRL_W-1:0] accuracy_control,
    input  alu_isa_pkg::opcode_e                  opcode,
    input  alu_isa_pkg::funct3_e                  funct3,
    input  alu_isa_pkg::funct7_e                  funct7,
    input  logic [alu_isa_pkg::XLEN-1:0]          rs1,
    input  logic [alu_isa_pkg::XLEN-1:0]          rs2,
    input  logic [alu_isa_pkg::XLEN-1:0]          immediate,
    output logic                                  out_valid,
    output logic [alu_isa_pkg::XLEN-1:0]          result,
    output logic                                  illegal
);

    import alu_isa_pkg::*;
    import alu_approx_pkg::*;

    alu_op_e            alu_op;
    logic               use_imm;
    logic               sub;
    logic [XLEN-1:0]    op_b;                  // rs2 or immediate
    logic [XLEN-1:0]    add_b;
    logic [XLEN-1:0]    add_sum;
    logic [XLEN-1:0]    res_d;                 // Next result
    logic [4:0]         shamt;
    logic               apx_en;
    logic [APX_LEN-1:0] err;

    alu_decoder u_dec (
        .opcode  (opcode),
        .funct3  (funct3),
        .funct7  (funct7),
        .alu_op  (alu_op),
        .use_imm (use_imm),
        .sub     (sub)
    );

    // ------------------------------------------------------------
    // Operands and adder
    // ------------------------------------------------------------
    assign op_b   = use_imm ? immediate : rs2;
    assign add_b  = sub ? ~op_b : op_b;        // Two's complement with cin
    assign shamt  = op_b[4:0];                 // Upper bits ignored
    assign apx_en = accuracy_control[APX_EN_BIT];
    assign err    = accuracy_control[ERR_LSB +: APX_LEN];

    approx_adder #(
        .APX_LEN (APX_LEN)
    ) u_add (
        .a      (rs1),
        .b      (add_b),
        .cin    (sub),
        .apx_en (apx_en),
        .err    (err),
        .sum    (add_sum)
    );

    always_comb begin
        case (alu_op)
            ALU_ADD, ALU_SUB: res_d = add_sum;
            ALU_SLL:  res_d = rs1 << shamt;
            ALU_SLT:  res_d = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(op_b)};
            ALU_SLTU: res_d = {{(XLEN-1){1'b0}}, rs1 < op_b};
            ALU_XOR:  res_d = rs1 ^ op_b;
            ALU_SRL:  res_d = rs1 >> shamt;
            ALU_SRA:  res_d = $signed(rs1) >>> shamt; // Sign fill
            ALU_OR:   res_d = rs1 | op_b;
            ALU_AND:  res_d = rs1 & op_b;
            default:  res_d = '0;              // Illegal gives zero
        endcase
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin                // Hold between strobes
                result  <= res_d;
                illegal <= (alu_op == ALU_ILLEGAL);
            end
        end
    end

    // Exactly one out_valid per strobe, one cycle later
    a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> out_valid);
    a_no_extra_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !in_valid |=> !out_valid);

endmodule

// ==== alu_decoder.sv ====
/*
  Decodes OP and OP_IMM into an ALU operation.
  funct7 is ignored where it is immediate bits, except for shifts.
  Any other opcode, and SLLI with nonzero funct7, is illegal.
*/
`timescale 1ns/1ps

module alu_decoder (
    input  alu_isa_pkg::opcode_e opcode,
    input  alu_isa_pkg::funct3_e funct3,
    input  alu_isa_pkg::funct7_e funct7,
    output alu_isa_pkg::alu_op_e alu_op,
    output logic                 use_imm,      // Operand two from immediate
    output logic                 sub           // Invert b and carry in 1
);

    import alu_isa_pkg::*;

    logic alt;                                 // funct7 selects SUB or SRA

    assign alt = (funct7 == F7_ALT);

    always_comb begin
        alu_op  = ALU_ILLEGAL;
        use_imm = 1'b0;
        sub     = 1'b0;
        case (opcode)
            // ------------------------------------------------------------
            // R-type
            // ------------------------------------------------------------
            OP: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        alu_op = alt ? ALU_SUB : ALU_ADD;
                        sub    = alt;
                    end
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SR:   alu_op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: alu_op = ALU_ILLEGAL;
                endcase
            end
            // ------------------------------------------------------------
            // I-type, no SUBI
            // ------------------------------------------------------------
            OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;  // ADDI
                    F3_SLL:     alu_op = (funct7 == F7_BASE) ? ALU_SLL : ALU_ILLEGAL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SR:      alu_op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    alu_op = ALU_ILLEGAL;
                endcase
            end
            default: alu_op = ALU_ILLEGAL;  // AUIPC and everything else
        endcase
    end

endmodule

// ==== approx_adder.sv ====
/*
  Approximate adder, low APX_LEN bits built from 4-bit blocks.
  APX_LEN must be a multiple of 4 from 4 to MAX_APX_LEN.
  Bits above APX_LEN are always exact. apx_en low forces every cell exact.
*/
`timescale 1ns/1ps

module approx_adder #(
    parameter int APX_LEN = 8
) (
    input  logic [alu_isa_pkg::XLEN-1:0] a,
    input  logic [alu_isa_pkg::XLEN-1:0] b,
    input  logic                         cin,
    input  logic                         apx_en,
    input  logic [APX_LEN-1:0]           err,
    output logic [alu_isa_pkg::XLEN-1:0] sum
);

    import alu_isa_pkg::*;
    import alu_approx_pkg::*;

    localparam int NBLK = APX_LEN / 4;         // Number of 4-bit blocks

    logic [APX_LEN-1:0] err_eff;
    logic [NBLK-1:0]    blk_carry;             // Carry out of each block
    logic [XLEN-1:0]    exact_sum;             // Reference for the check

    if ((APX_LEN % 4) != 0 || APX_LEN < 4 || APX_LEN > MAX_APX_LEN) begin : g_len_check
        $error("APX_LEN must be a multiple of 4 from 4 to %0d", MAX_APX_LEN);
    end

    assign err_eff = err | {APX_LEN{~apx_en}}; // Disabled means all exact

    // ------------------------------------------------------------
    // Lowest block, plain error-configurable ripple
    // ------------------------------------------------------------
    ec_ripple_adder #(
        .WIDTH (4)
    ) u_low (
        .a    (a[3:0]),
        .b    (b[3:0]),
        .err  (err_eff[3:0]),
        .cin  (cin),
        .sum  (sum[3:0]),
        .cout (blk_carry[0])
    );

    for (genvar k = 1; k < NBLK; k++) begin : g_csb
        carry_select_block u_csb (
            .a       (a[4*k +: 4]),
            .b       (b[4*k +: 4]),
            .err     (err_eff[4*k+1 +: 3]), // Block bit 0 has no error bit
            .cin_sel (blk_carry[k-1]),
            .sum     (sum[4*k +: 4]),
            .cout    (blk_carry[k])
        );
    end

    // Exact upper part
    assign sum[XLEN-1:APX_LEN] = a[XLEN-1:APX_LEN] + b[XLEN-1:APX_LEN] +
                                 {{(XLEN-APX_LEN-1){1'b0}}, blk_carry[NBLK-1]};

    assign exact_sum = a + b + {{(XLEN-1){1'b0}}, cin};

    // Every block is exact when disabled, so the chain must match a full add
    always_comb begin
        if (!apx_en && !$isunknown({a, b, cin})) begin
            a_exact_when_off: assert (sum == exact_sum)
                else $error("approx_adder: inexact sum with approximation off");
        end
    end

endmodule

// ==== carry_select_block.sv ====
/*
  One approximate 4-bit carry-select block.
  Bit 0 is a plain half adder and has no error control.
  The incremented candidate is taken when the carry below is set.
*/
`timescale 1ns/1ps

module carry_select_block (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic [2:0] err,                    // Error bits for block bits 3:1
    input  logic       cin_sel,                // Carry out of the block below
    output logic [3:0] sum,
    output logic       cout
);

    logic       ha_carry;
    logic [3:0] rca_sum;                       // Candidate for carry in 0
    logic       rca_carry;
    logic [3:0] inc_sum;                       // Candidate for carry in 1
    logic       inc_carry;

    // ------------------------------------------------------------
    // Half adder on bit 0, ripple on bits 3:1
    // ------------------------------------------------------------
    assign rca_sum[0] = a[0] ^ b[0];
    assign ha_carry   = a[0] & b[0];

    ec_ripple_adder #(
        .WIDTH (3)
    ) u_rca (
        .a    (a[3:1]),
        .b    (b[3:1]),
        .err  (err),
        .cin  (ha_carry),
        .sum  (rca_sum[3:1]),
        .cout (rca_carry)
    );

    // ------------------------------------------------------------
    // Incrementer, carry out only when all four bits are set
    // ------------------------------------------------------------
    assign inc_sum[0] = ~rca_sum[0];
    assign inc_sum[1] = rca_sum[1] ^ rca_sum[0];
    assign inc_sum[2] = rca_sum[2] ^ (rca_sum[1] & rca_sum[0]);
    assign inc_sum[3] = rca_sum[3] ^ (&rca_sum[2:0]);
    assign inc_carry  = &rca_sum;

    // Select on the incoming carry
    assign sum  = cin_sel ? inc_sum : rca_sum;
    assign cout = rca_carry | (cin_sel & inc_carry); // Ripple and increment never both carry

endmodule

// ==== ec_ripple_adder.sv ====
/*
  Ripple adder of error-configurable full adder cells.
  err bit 1 gives an exact cell, 0 gives the approximate cell.
  Purely combinational, carry delay grows with WIDTH.
*/
`timescale 1ns/1ps

module ec_ripple_adder #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] err,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH:0] carry;                     // carry[i] enters cell i

    assign carry[0] = cin;

    for (genvar i = 0; i < WIDTH; i++) begin : g_cell
        logic p;                               // Propagate

        assign p = a[i] ^ b[i];

        // Exact is p ^ cin, approximate is p | cin
        assign sum[i] = err[i] ? (p ^ carry[i]) : (p | carry[i]);

        // Approximate carry drops the b & cin term
        assign carry[i+1] = (a[i] & (b[i] | carry[i])) |
                            (err[i] & b[i] & carry[i]);
    end

    assign cout = carry[WIDTH];

endmodule

// ==== alu_approx_pkg.sv ====
/*
  Layout of the 32-bit accuracy control word.
  Bits 2:1 are reserved, there is a single adder circuit.
  Error field bit n controls adder bit n, a 1 makes it exact.
*/

package alu_approx_pkg;

    localparam int ACC_CTRL_W  = 32;           // Whole control word

    // 1 enables approximation, 0 gives an exact adder
    localparam int APX_EN_BIT  = 0;

    // First bit of the per-bit error field
    localparam int ERR_LSB     = 3;

    // Error field must fit above ERR_LSB, rounded down to 4-bit blocks
    localparam int MAX_APX_LEN = 28;

endpackage

// ==== alu_isa_pkg.sv ====
/*
  RV32I definitions for the OP and OP_IMM groups only.
  Enum members carry a prefix because funct3 and ALU op names overlap.
  Opcodes outside opcode_e arrive by cast and decode as illegal.
*/

package alu_isa_pkg;

    localparam int XLEN = 32;                  // Data path width

    // ------------------------------------------------------------
    // Major opcodes, only two are decoded
    // ------------------------------------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b01_100_11,                 // R-type register-register
        OP_IMM = 7'b00_100_11                  // I-type register-immediate
    } opcode_e;

    // Shared by R-type and I-type
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,                   // ADD, SUB, ADDI
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,                   // SRL and SRA share this code
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    typedef enum logic [6:0] {
        F7_BASE = 7'b000_0000,
        F7_ALT  = 7'b010_0000                  // Bit 5 picks SUB or SRA
    } funct7_e;

    // ------------------------------------------------------------
    // Internal operation code from the decoder
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_ILLEGAL                            // Result forced to zero
    } alu_op_e;

endpackage
